// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run tb_cam_fifo, check $(LOG)"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -f all.f --top-module tb_cam_fifo -o sim_tb
	./obj_dir/sim_tb > $(LOG)
	cat $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "FAIL"; exit 1; else echo "PASS"; fi

clean:
	rm -rf obj_dir $(LOG)

// File: all.f
cam_pkg.sv
bus_pkg.sv
cam_word_packer.sv
fifo_bank_router.sv
sync_fifo.sv
wb_reg_file.sv
cam_fifo_top.sv
tb_cam_fifo.sv

// File: bus_pkg.sv
// Register bus widths, register map, reset values and bus request type
package bus_pkg;

    // --------------------
    // Bus geometry
    // --------------------
    localparam int ADDR_W = 9;             // Up to 512 word addresses
    localparam int DATA_W = 32;

    // Banks served by the map below
    localparam int MAP_BANKS = 3;

    // --------------------
    // Register map
    // --------------------
    localparam logic [ADDR_W-1:0] REG_ID_ADR       = 9'h000;
    localparam logic [ADDR_W-1:0] REG_REV_ADR      = 9'h001;
    localparam logic [ADDR_W-1:0] REG_GPIO_IN_ADR  = 9'h002;
    localparam logic [ADDR_W-1:0] REG_GPIO_OUT_ADR = 9'h003;
    localparam logic [ADDR_W-1:0] REG_GPIO_OE_ADR  = 9'h004;

    // Bank data ports pop on read, index 0 is the lowest bank
    localparam logic [MAP_BANKS-1:0][ADDR_W-1:0] BANK_DATA_ADR = {9'h100, 9'h080, 9'h040};
    // Flag registers sit one above each data port
    localparam logic [MAP_BANKS-1:0][ADDR_W-1:0] BANK_FLAG_ADR = {9'h101, 9'h081, 9'h041};

    // --------------------
    // Fixed values
    // --------------------
    localparam logic [DATA_W-1:0] DEVICE_ID     = 32'hF1F0_7E57;
    localparam logic [15:0]       REV_NUM       = 16'h0100;
    localparam logic [DATA_W-1:0] DEF_REG_VALUE = 32'hFABD_EFAC;   // Unmapped or empty reads

    // Request fields driven by the bus master
    typedef struct packed {
        logic [ADDR_W-1:0] adr;
        logic              we;             // 1 = write
        logic [3:0]        byte_stb;
        logic [DATA_W-1:0] dat;            // Write data
    } wb_req_t;

endpackage

// File: cam_fifo_top.sv
// Top level of the capture pipeline: packer, router, FIFO banks, register file
`timescale 1ns/100ps

module cam_fifo_top
    import cam_pkg::*;
    import bus_pkg::*;
#(
    parameter int FIFO_DEPTH = 512
)
(
    input  logic              PCLKI,
    input  logic              WBs_RST_i,
    input  logic              vsync_i,
    input  logic              href_i,
    input  logic              wbs_cyc_i,
    input  logic              wbs_stb_i,
    input  wb_req_t           wbs_req_i,
    input  logic [7:0]        gpio_in_i,
    output logic [DATA_W-1:0] wbs_dat_o,
    output logic              wbs_ack_o,
    output logic [7:0]        gpio_out_o,
    output logic [7:0]        gpio_oe_o
);

    logic                           word_done;
    logic         [NUM_BANKS-1:0]   push;
    logic         [NUM_BANKS-1:0]   pop;
    logic         [NUM_BANKS-1:0]   bank_full;
    cam_word_t                      word;
    cam_word_t    [NUM_BANKS-1:0]   bank_dout;
    bank_status_t [NUM_BANKS-1:0]   bank_status;

    cam_word_packer u_packer (
        .PCLKI       (PCLKI),
        .WBs_RST_i   (WBs_RST_i),
        .vsync_i     (vsync_i),
        .href_i      (href_i),
        .word_done_o (word_done)
    );

    fifo_bank_router #(.FIFO_DEPTH(FIFO_DEPTH)) u_router (
        .PCLKI       (PCLKI),
        .WBs_RST_i   (WBs_RST_i),
        .word_done_i (word_done),
        .bank_full_i (bank_full),
        .push_o      (push),
        .word_o      (word)
    );

    // --------------------
    // FIFO banks
    // --------------------
    for (genvar g = 0; g < NUM_BANKS; g++)
    begin : g_bank
        sync_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
            .PCLKI     (PCLKI),
            .WBs_RST_i (WBs_RST_i),
            .push_i    (push[g]),
            .pop_i     (pop[g]),
            .din_i     (word),
            .dout_o    (bank_dout[g]),
            .status_o  (bank_status[g])
        );
        assign bank_full[g] = bank_status[g].full;    // Back-pressure to router
    end

    wb_reg_file u_regs (
        .PCLKI         (PCLKI),
        .WBs_RST_i     (WBs_RST_i),
        .wbs_cyc_i     (wbs_cyc_i),
        .wbs_stb_i     (wbs_stb_i),
        .wbs_req_i     (wbs_req_i),
        .gpio_in_i     (gpio_in_i),
        .bank_status_i (bank_status),
        .bank_dout_i   (bank_dout),
        .pop_o         (pop),
        .wbs_dat_o     (wbs_dat_o),
        .wbs_ack_o     (wbs_ack_o),
        .gpio_out_o    (gpio_out_o),
        .gpio_oe_o     (gpio_oe_o)
    );

endmodule

// File: cam_pkg.sv
// Capture word and FIFO bank types, bank count and beats per word
package cam_pkg;

    // --------------------
    // Capture geometry
    // --------------------
    localparam int NUM_BANKS      = 3;     // Fixed by the register map
    localparam int BEATS_PER_WORD = 4;     // Valid pixel beats per capture word

    localparam int CAM_WORD_W = 32;
    localparam int LEVEL_W    = 16;        // Width of the reported fill level

    // --------------------
    // Types
    // --------------------

    // Capture word, sequence number zero-extended to 32 bits
    typedef logic [CAM_WORD_W-1:0] cam_word_t;

    // Per-bank status as seen by the register file
    typedef struct packed {
        logic [LEVEL_W-1:0] level;         // Words currently stored
        logic               empty;
        logic               full;
    } bank_status_t;

endpackage

// File: cam_word_packer.sv
// Pixel beat counter that pulses once per completed capture word
`timescale 1ns/100ps

module cam_word_packer
    import cam_pkg::*;
(
    input  logic PCLKI,
    input  logic WBs_RST_i,
    input  logic vsync_i,
    input  logic href_i,
    output logic word_done_o
);

    localparam int CNT_W = $clog2(BEATS_PER_WORD);
    localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(BEATS_PER_WORD - 1);

    logic             beat_valid;
    logic [CNT_W-1:0] beat_cnt_q;

    // A beat only counts inside an active line of an active frame
    assign beat_valid = vsync_i & href_i;

    // --------------------
    // Beat counter
    // --------------------
    always_ff @(posedge PCLKI or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            beat_cnt_q  <= '0;
            word_done_o <= 1'b0;
        end
        else
        begin
            word_done_o <= 1'b0;
            if (beat_valid)
            begin
                if (beat_cnt_q == LAST_BEAT)
                begin
                    beat_cnt_q  <= '0;            // Wrap on the last beat
                    word_done_o <= 1'b1;
                end
                else
                begin
                    beat_cnt_q <= beat_cnt_q + 1'b1;
                end
            end
        end
    end

    // Words are at least BEATS_PER_WORD cycles apart
    a_word_done_single : assert property (
        @(posedge PCLKI) disable iff (WBs_RST_i)
        word_done_o |=> !word_done_o
    );

endmodule

// File: fifo_bank_router.sv
// Sequence numbering of capture words and push steering to the FIFO banks
`timescale 1ns/100ps

module fifo_bank_router
    import cam_pkg::*;
#(
    parameter int FIFO_DEPTH = 512
)
(
    input  logic                 PCLKI,
    input  logic                 WBs_RST_i,
    input  logic                 word_done_i,
    input  logic [NUM_BANKS-1:0] bank_full_i,
    output logic [NUM_BANKS-1:0] push_o,
    output cam_word_t            word_o
);

    // Sequence numbers cover all banks once, then wrap
    localparam int SEQ_MAX = NUM_BANKS * FIFO_DEPTH;
    localparam int SEQ_W   = $clog2(SEQ_MAX);
    localparam int BANK_W  = $clog2(NUM_BANKS);

    localparam logic [SEQ_W-1:0] SEQ_LAST = SEQ_W'(SEQ_MAX - 1);
    localparam logic [SEQ_W-1:0] DEPTH_C  = SEQ_W'(FIFO_DEPTH);

    logic [SEQ_W-1:0]     seq_q;
    logic [BANK_W-1:0]    bank_sel;
    logic [NUM_BANKS-1:0] push_nxt;

    // Range of the sequence number picks the bank
    assign bank_sel = BANK_W'(seq_q / DEPTH_C);

    always_comb
    begin
        push_nxt           = '0;
        push_nxt[bank_sel] = ~bank_full_i[bank_sel];   // Drop when full
    end

    // --------------------
    // Sequence and push
    // --------------------
    always_ff @(posedge PCLKI or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            seq_q  <= '0;
            push_o <= '0;
        end
        else
        begin
            push_o <= '0;
            if (word_done_i)
            begin
                push_o <= push_nxt;
                // Dropped words still use up their number
                seq_q  <= (seq_q == SEQ_LAST) ? '0 : seq_q + 1'b1;
            end
        end
    end

    // Word payload follows the current number
    always_ff @(posedge PCLKI)
    begin
        if (word_done_i)
            word_o <= cam_word_t'(seq_q);
    end

endmodule

// File: sync_fifo.sv
// Synchronous circular-buffer FIFO bank with fill level, empty and full
`timescale 1ns/100ps

module sync_fifo
    import cam_pkg::*;
#(
    parameter int FIFO_DEPTH = 512
)
(
    input  logic         PCLKI,
    input  logic         WBs_RST_i,
    input  logic         push_i,
    input  logic         pop_i,
    input  cam_word_t    din_i,
    output cam_word_t    dout_o,
    output bank_status_t status_o
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int LVL_W = $clog2(FIFO_DEPTH + 1);

    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(FIFO_DEPTH - 1);
    localparam logic [LVL_W-1:0] LVL_FULL = LVL_W'(FIFO_DEPTH);

    cam_word_t        mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [LVL_W-1:0] level_q;
    logic             empty;
    logic             full;
    logic             wr_en;
    logic             rd_en;

    assign empty = (level_q == '0);
    assign full  = (level_q == LVL_FULL);

    assign wr_en = push_i & ~full;         // Guarded in case of overrun
    assign rd_en = pop_i & ~empty;

    // --------------------
    // Storage
    // --------------------
    always_ff @(posedge PCLKI)
    begin
        if (wr_en)
            mem_q[wr_ptr_q] <= din_i;
    end

    // --------------------
    // Pointers and level
    // --------------------
    always_ff @(posedge PCLKI or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            level_q  <= '0;
        end
        else
        begin
            if (wr_en)
                wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
            if (rd_en)
                rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;

            // Simultaneous push and pop leave the level alone
            case ({wr_en, rd_en})
                2'b10:   level_q <= level_q + 1'b1;
                2'b01:   level_q <= level_q - 1'b1;
                default: level_q <= level_q;
            endcase
        end
    end

    assign dout_o         = mem_q[rd_ptr_q];          // Head word
    assign status_o.level = LEVEL_W'(level_q);
    assign status_o.empty = empty;
    assign status_o.full  = full;

    // Router must not push into a full bank
    a_no_push_full : assert property (
        @(posedge PCLKI) disable iff (WBs_RST_i)
        push_i |-> !full
    );

    // Register file only pops a bank it saw non-empty
    a_no_pop_empty : assert property (
        @(posedge PCLKI) disable iff (WBs_RST_i)
        pop_i |-> !empty
    );

endmodule

// File: tb_cam_fifo.sv
// Directed testbench for the camera capture FIFO top level with typed checks
`timescale 1ns/100ps

module tb_cam_fifo
    import cam_pkg::*;
    import bus_pkg::*;
();

    localparam int          DEPTH       = 16;
    localparam int          DRV_DLY     = 10;            // Input skew after the rising edge
    localparam int          ACK_TIMEOUT = 20;            // Cycles allowed for an ack
    localparam logic [31:0] SEED        = 32'h98a3_d84d;

    logic              PCLKI;
    logic              WBs_RST_i;
    logic              vsync_i;
    logic              href_i;
    logic              wbs_cyc_i;
    logic              wbs_stb_i;
    wb_req_t           wbs_req_i;
    logic [7:0]        gpio_in_i;
    logic [DATA_W-1:0] wbs_dat_o;
    logic              wbs_ack_o;
    logic [7:0]        gpio_out_o;
    logic [7:0]        gpio_oe_o;

    int err_cnt;
    int check_cnt;
    int test_err_base;

    cam_fifo_top #(.FIFO_DEPTH(DEPTH)) UUT (.*);

    initial
    begin
        PCLKI = 1'b0;
        forever #50 PCLKI = ~PCLKI;
    end

    // --------------------
    // Typed compares
    // --------------------
    task automatic check_data(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                              input string what);
        check_cnt++;
        if (got !== exp)
        begin
            err_cnt++;
            $display("Mismatch at %0t: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input cam_word_t got, input cam_word_t exp, input string what);
        check_cnt++;
        if (got !== exp)
        begin
            err_cnt++;
            $display("Mismatch at %0t: %s word %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_status(input bank_status_t got, input bank_status_t exp,
                                input string what);
        check_cnt++;
        if (got !== exp)
        begin
            err_cnt++;
            $display("Mismatch at %0t: %s level %0d empty %b full %b, expected %0d %b %b",
                     $time, what, got.level, got.empty, got.full, exp.level, exp.empty, exp.full);
        end
    endtask

    task automatic check_ack(input logic got, input logic exp, input string what);
        check_cnt++;
        if (got !== exp)
        begin
            err_cnt++;
            $display("Mismatch at %0t: ack %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    function automatic bank_status_t make_status(input int level, input logic empty,
                                                 input logic full);
        bank_status_t s;
        s.level = 16'(level);
        s.empty = empty;
        s.full  = full;
        return s;
    endfunction

    // --------------------
    // Bus and pixel drivers
    // --------------------
    task automatic bus_cycle(input logic [ADDR_W-1:0] adr, input logic we,
                             input logic [3:0] byte_stb, input logic [DATA_W-1:0] dat,
                             output logic [DATA_W-1:0] rdata);
        int   waited;
        logic acked;
        logic first_ack;
        wbs_req_i = '{adr: adr, we: we, byte_stb: byte_stb, dat: dat};
        wbs_cyc_i = 1'b1;
        wbs_stb_i = 1'b1;
        waited    = 0;
        acked     = 1'b0;
        first_ack = 1'b0;
        while (!acked && waited < ACK_TIMEOUT)
        begin
            @(posedge PCLKI);
            #DRV_DLY;
            waited++;
            acked = wbs_ack_o;
            if (waited == 1)
                first_ack = wbs_ack_o;
        end
        if (!acked)
        begin
            $display("Timeout: no bus acknowledge for address %h after %0d cycles", adr, waited);
            $display("Errors found");
            $finish;
        end
        else
        begin
            rdata     = wbs_dat_o;             // Valid while ack is high
            check_ack(first_ack, 1'b1, "one cycle after the request");
            wbs_cyc_i = 1'b0;
            wbs_stb_i = 1'b0;
            @(posedge PCLKI);                  // Bank pop lands on this edge
            #DRV_DLY;
            check_ack(wbs_ack_o, 1'b0, "one cycle after it rose");
            wbs_req_i.we = 1'b0;
        end
    endtask

    task automatic bus_write(input logic [ADDR_W-1:0] adr, input logic [3:0] byte_stb,
                             input logic [DATA_W-1:0] dat);
        logic [DATA_W-1:0] unused_rd;
        bus_cycle(adr, 1'b1, byte_stb, dat, unused_rd);
    endtask

    task automatic bus_read(input logic [ADDR_W-1:0] adr, output logic [DATA_W-1:0] rdata);
        bus_cycle(adr, 1'b0, 4'hF, '0, rdata);
    endtask

    // Four valid beats per word with random idle or half-valid gaps
    task automatic push_beats(input int n_words);
        int gaps;
        int kind;
        for (int w = 0; w < n_words; w++)
        begin
            for (int b = 0; b < 4; b++)
            begin
                gaps = $urandom % 3;
                for (int g = 0; g < gaps; g++)
                begin
                    kind    = $urandom % 3;
                    vsync_i = (kind == 1);
                    href_i  = (kind == 2);
                    @(posedge PCLKI);
                    #DRV_DLY;
                end
                vsync_i = 1'b1;
                href_i  = 1'b1;
                @(posedge PCLKI);
                #DRV_DLY;
            end
        end
        vsync_i = 1'b0;
        href_i  = 1'b0;
        repeat (3) @(posedge PCLKI);           // Last word reaches its bank
        #DRV_DLY;
    endtask

    task automatic apply_reset();
        WBs_RST_i = 1'b1;
        repeat (8) @(posedge PCLKI);
        #DRV_DLY;
        WBs_RST_i = 1'b0;
    endtask

    task automatic expect_status(input int b, input int level, input logic empty,
                                 input logic full);
        logic [DATA_W-1:0] d;
        bank_status_t      st;
        bus_read(BANK_FLAG_ADR[b], d);
        st.level = d[15:0];
        st.empty = d[16];
        st.full  = d[17];
        check_status(st, make_status(level, empty, full), $sformatf("bank %0d flags", b));
    endtask

    task automatic drain_bank(input int b, input int first, input int count);
        logic [DATA_W-1:0] d;
        for (int k = 0; k < count; k++)
        begin
            bus_read(BANK_DATA_ADR[b], d);
            check_word(cam_word_t'(d), cam_word_t'(first + k), $sformatf("bank %0d data", b));
        end
    endtask

    task automatic finish_test(input string name);
        $display("Test %-12s done, %0d errors", name, err_cnt - test_err_base);
        test_err_base = err_cnt;
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic test_reset_values();
        logic [DATA_W-1:0] d;
        check_data({24'h0, gpio_out_o}, 32'h0, "gpio_out_o");
        check_data({24'h0, gpio_oe_o}, 32'h0, "gpio_oe_o");
        bus_read(REG_ID_ADR, d);
        check_data(d, 32'hF1F0_7E57, "device ID");
        bus_read(REG_REV_ADR, d);
        check_data(d, 32'h0000_0100, "revision");
        bus_read(9'h005, d);
        check_data(d, 32'hFABD_EFAC, "unmapped address");
        for (int b = 0; b < 3; b++)
            expect_status(b, 0, 1'b1, 1'b0);
        finish_test("reset");
    endtask

    task automatic test_gpio();
        logic [DATA_W-1:0] d;
        bus_write(REG_GPIO_OUT_ADR, 4'b0001, 32'h0000_00A5);
        bus_write(REG_GPIO_OE_ADR, 4'b1111, 32'h0000_003C);
        check_data({24'h0, gpio_out_o}, 32'hA5, "gpio_out_o after write");
        check_data({24'h0, gpio_oe_o}, 32'h3C, "gpio_oe_o after write");
        bus_write(REG_GPIO_OUT_ADR, 4'b1110, 32'h0000_005A);   // Lane 0 off
        bus_write(REG_GPIO_OE_ADR, 4'b0000, 32'h0000_00FF);
        check_data({24'h0, gpio_out_o}, 32'hA5, "gpio_out_o without lane 0");
        check_data({24'h0, gpio_oe_o}, 32'h3C, "gpio_oe_o without lane 0");
        bus_read(REG_GPIO_OUT_ADR, d);
        check_data(d, 32'hA5, "GPIO out register");
        bus_read(REG_GPIO_IN_ADR, d);
        check_data(d, {24'h0, gpio_in_i}, "GPIO in register");
        finish_test("gpio");
    endtask

    task automatic test_capture();
        int n_words = 5;
        push_beats(n_words);
        expect_status(0, n_words, 1'b0, 1'b0);
        drain_bank(0, 0, n_words);
        expect_status(0, 0, 1'b1, 1'b0);
        finish_test("capture");
    endtask

    task automatic test_rollover();
        apply_reset();
        push_beats(20);
        expect_status(0, 16, 1'b0, 1'b1);
        expect_status(1, 4, 1'b0, 1'b0);
        drain_bank(1, 16, 4);
        drain_bank(0, 0, 16);
        finish_test("rollover");
    endtask

    task automatic test_overflow();
        apply_reset();
        push_beats(52);                        // Last four wrap onto a full bank 0
        expect_status(0, 16, 1'b0, 1'b1);
        expect_status(1, 16, 1'b0, 1'b1);
        expect_status(2, 16, 1'b0, 1'b1);
        drain_bank(0, 0, 16);
        drain_bank(1, 16, 16);
        drain_bank(2, 32, 16);
        for (int b = 0; b < 3; b++)
            expect_status(b, 0, 1'b1, 1'b0);
        finish_test("overflow");
    endtask

    task automatic test_empty_read();
        logic [DATA_W-1:0] d;
        for (int b = 0; b < 3; b++)
        begin
            bus_read(BANK_DATA_ADR[b], d);
            check_data(d, 32'hFABD_EFAC, $sformatf("empty bank %0d data", b));
            expect_status(b, 0, 1'b1, 1'b0);
        end
        finish_test("empty read");
    endtask

    initial
    begin
        void'($urandom(SEED));
        err_cnt       = 0;
        check_cnt     = 0;
        test_err_base = 0;
        WBs_RST_i     = 1'b1;
        vsync_i       = 1'b0;
        href_i        = 1'b0;
        wbs_cyc_i     = 1'b0;
        wbs_stb_i     = 1'b0;
        wbs_req_i     = '0;
        gpio_in_i     = 8'h96;
        apply_reset();
        test_reset_values();
        test_gpio();
        test_capture();
        test_rollover();
        test_overflow();
        test_empty_read();
        $display("Checks %0d, errors %0d", check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// File: wb_reg_file.sv
// Register bus decode, acknowledge, GPIO registers, read mux and bank pops
`timescale 1ns/100ps

module wb_reg_file
    import cam_pkg::*;
    import bus_pkg::*;
(
    input  logic                                PCLKI,
    input  logic                                WBs_RST_i,
    input  logic                                wbs_cyc_i,
    input  logic                                wbs_stb_i,
    input  wb_req_t                             wbs_req_i,
    input  logic         [7:0]                  gpio_in_i,
    input  bank_status_t [NUM_BANKS-1:0]        bank_status_i,
    input  cam_word_t    [NUM_BANKS-1:0]        bank_dout_i,
    output logic         [NUM_BANKS-1:0]        pop_o,
    output logic         [DATA_W-1:0]           wbs_dat_o,
    output logic                                wbs_ack_o,
    output logic         [7:0]                  gpio_out_o,
    output logic         [7:0]                  gpio_oe_o
);

    logic              req_new;            // Request not yet acknowledged
    logic              wr_req;
    logic              gpio_out_wr;
    logic              gpio_oe_wr;
    logic [DATA_W-1:0] rd_data;

    // --------------------
    // Decode
    // --------------------
    assign req_new = wbs_cyc_i & wbs_stb_i & ~wbs_ack_o;
    assign wr_req  = req_new & wbs_req_i.we;

    // GPIO registers only take byte lane 0
    assign gpio_out_wr = wr_req & (wbs_req_i.adr == REG_GPIO_OUT_ADR) & wbs_req_i.byte_stb[0];
    assign gpio_oe_wr  = wr_req & (wbs_req_i.adr == REG_GPIO_OE_ADR) & wbs_req_i.byte_stb[0];

    // --------------------
    // Ack and GPIO
    // --------------------
    always_ff @(posedge PCLKI or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            wbs_ack_o  <= 1'b0;
            gpio_out_o <= 8'h00;
            gpio_oe_o  <= 8'h00;
        end
        else
        begin
            wbs_ack_o <= req_new;          // One-cycle pulse per request
            if (gpio_out_wr)
                gpio_out_o <= wbs_req_i.dat[7:0];
            if (gpio_oe_wr)
                gpio_oe_o <= wbs_req_i.dat[7:0];
        end
    end

    // --------------------
    // Read mux
    // --------------------
    always_comb
    begin
        case (wbs_req_i.adr)
            REG_ID_ADR:       rd_data = DEVICE_ID;
            REG_REV_ADR:      rd_data = DATA_W'(REV_NUM);
            REG_GPIO_IN_ADR:  rd_data = DATA_W'(gpio_in_i);
            REG_GPIO_OUT_ADR: rd_data = DATA_W'(gpio_out_o);
            REG_GPIO_OE_ADR:  rd_data = DATA_W'(gpio_oe_o);
            default:          rd_data = DEF_REG_VALUE;
        endcase

        for (int b = 0; b < NUM_BANKS; b++)
        begin
            // Empty bank reads the default pattern, not stale memory
            if (wbs_req_i.adr == BANK_DATA_ADR[b])
                rd_data = bank_status_i[b].empty ? DEF_REG_VALUE : bank_dout_i[b];
            if (wbs_req_i.adr == BANK_FLAG_ADR[b])
                rd_data = {14'h0, bank_status_i[b].full, bank_status_i[b].empty,
                           bank_status_i[b].level};
        end
    end

    assign wbs_dat_o = rd_data;

    // Pop at the edge closing the ack cycle, after the head has been read
    always_comb
    begin
        for (int b = 0; b < NUM_BANKS; b++)
        begin
            pop_o[b] = wbs_ack_o & ~wbs_req_i.we
                     & (wbs_req_i.adr == BANK_DATA_ADR[b])
                     & ~bank_status_i[b].empty;
        end
    end

    a_ack_single : assert property (
        @(posedge PCLKI) disable iff (WBs_RST_i)
        wbs_ack_o |=> !wbs_ack_o
    );

endmodule
